/* sources.f */
hdl/booth_pkg.sv
hdl/booth_datapath.sv
hdl/booth_control.sv
hdl/result_arbiter.sv
hdl/result_ram.sv
hdl/mul_cluster.sv
tb/tb_mul_cluster.sv

/* tb/golden_vectors.txt */
# mode lane multiplier multiplicand dest product, all fields hex
# mode 0 solo, 1 pair with next line, 2 start while busy (ignored), 3 restart as busy falls
1 0 0003 0005 0 0000000f
1 1 fffd 0007 1 ffffffeb
0 0 1234 0056 2 00061d78
0 1 ff38 012c 3 ffff15a0
0 0 fc18 ff9c 4 000186a0
0 1 0000 7abc 5 00000000
0 0 5a5a 0000 6 00000000
0 1 0001 8001 7 ffff8001
0 0 ffff 4321 8 ffffbcdf
0 1 8000 8000 9 40000000
0 0 7fff 8000 a c0008000
0 1 8000 ffff b 00008000
0 0 ffff ffff c 00000001
0 1 2710 0d05 d 01fc9350
2 1 0002 0002 3 ffff15a0
0 0 8001 0003 e fffe8003
3 0 0006 0007 f 0000002a
1 1 0064 ff9c 0 ffffd8f0
1 0 0b0b 0202 1 00162c16
0 1 7fff 7fff 2 3fff0001
0 0 00ff ff01 5 ffff01ff
0 1 a5a5 5a5a 6 e01c3e02
0 0 0002 c000 7 ffff8000
0 1 4000 4000 8 10000000
0 0 8000 0001 9 ffff8000
0 1 0001 0001 a 00000001
0 0 fffe 7fff b ffff0002
0 1 0000 0000 c 00000000

/* tb/tb_mul_cluster.sv */
module tb_mul_cluster;

    import booth_pkg::*;

    localparam int max_vec   = 64;
    localparam int run_edges = iter_count + 3;   // Load, iterations, done check, write

    logic                  clk;
    logic                  rst_n;
    logic                  start0;
    logic [op_width-1:0]   mplier0;
    logic [op_width-1:0]   mcand0;
    logic [addr_width-1:0] dest0;
    logic                  busy0;
    logic                  start1;
    logic [op_width-1:0]   mplier1;
    logic [op_width-1:0]   mcand1;
    logic [addr_width-1:0] dest1;
    logic                  busy1;
    logic [addr_width-1:0] rd_addr;
    logic [prod_width-1:0] rd_data;

    // Golden vectors, one slot per file line
    int                    v_mode   [max_vec];   // 0 solo, 1 pair, 2 ignored, 3 restart
    int                    v_lane   [max_vec];
    logic [op_width-1:0]   v_mplier [max_vec];
    logic [op_width-1:0]   v_mcand  [max_vec];
    logic [addr_width-1:0] v_dest   [max_vec];
    logic [prod_width-1:0] v_prod   [max_vec];
    int                    num_vec;
    logic                  vec_loaded;

    // Expected RAM image, in completion order
    logic [prod_width-1:0] exp_mem   [ram_depth];
    logic                  exp_valid [ram_depth];

    int                    data_errs;
    int                    timing_errs;
    int                    vec_errs;
    int                    prio_lane;   // Lane the round-robin pointer favours next

    mul_cluster dut0 (
        .clk(clk), .rst_n(rst_n),
        .start0(start0), .mplier0(mplier0), .mcand0(mcand0), .dest0(dest0), .busy0(busy0),
        .start1(start1), .mplier1(mplier1), .mcand1(mcand1), .dest1(dest1), .busy1(busy1),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic read_vectors();
        int                    fd;
        int                    cnt;
        string                 line;
        int                    mode;
        int                    lane;
        logic [op_width-1:0]   a;
        logic [op_width-1:0]   b;
        logic [addr_width-1:0] d;
        logic [prod_width-1:0] p;
        num_vec = 0;
        fd = $fopen("tb/golden_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden vector file");
            vec_errs++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            if (line.len() > 0 && line[0] != "#" && line[0] != "\n") begin   // Skip notes
                cnt = $sscanf(line, "%h %h %h %h %h %h", mode, lane, a, b, d, p);
                if (cnt != 6) begin
                    $display("Golden file line could not be parsed: %s", line);
                    vec_errs++;
                end else if (num_vec < max_vec) begin
                    v_mode[num_vec]   = mode;
                    v_lane[num_vec]   = lane;
                    v_mplier[num_vec] = a;
                    v_mcand[num_vec]  = b;
                    v_dest[num_vec]   = d;
                    v_prod[num_vec]   = p;
                    num_vec++;
                end
            end
        end
        $fclose(fd);
        if (num_vec == 0) begin
            $display("No vectors were found in the golden file");
            vec_errs++;
        end
    endtask

    // Operands, destination and start level onto the vector's lane
    task automatic apply_inputs(input int i, input logic st);
        if (v_lane[i] == 0) begin
            start0  <= st;
            mplier0 <= v_mplier[i];
            mcand0  <= v_mcand[i];
            dest0   <= v_dest[i];
        end else begin
            start1  <= st;
            mplier1 <= v_mplier[i];
            mcand1  <= v_mcand[i];
            dest1   <= v_dest[i];
        end
    endtask

    task automatic drop_start(input int lane);
        if (lane == 0) begin
            start0 <= 1'b0;
        end else begin
            start1 <= 1'b0;
        end
    endtask

    function automatic logic lane_busy(input int lane);
        return (lane == 0) ? busy0 : busy1;
    endfunction

    task automatic idle_gap();
        int gap;
        gap = $urandom % 4;   // 0 to 3 idle cycles
        repeat (gap) @(posedge clk);
    endtask

    task automatic check_edges(input int lane, input int expected, input int actual);
        if (actual != expected) begin
            $display("Fail at time %0t: busy%0d edges to fall expected %0d actual %0d",
                     $time, lane, expected, actual);
            timing_errs++;
        end
    endtask

    // One registered read of the result RAM
    task automatic check_word(input logic [addr_width-1:0] addr,
                              input logic [prod_width-1:0] expected);
        @(posedge clk);
        rd_addr <= addr;
        @(posedge clk);   // Address sampled by the RAM
        @(negedge clk);
        if (rd_data !== expected) begin
            $display("Fail at time %0t: rd_data at address %0d expected %h actual %h",
                     $time, addr, expected, rd_data);
            data_errs++;
        end
    endtask

    task automatic record_result(input int i);
        if (v_mode[i] == 2) begin
            // Ignored start, destination must already hold this word
            if (!exp_valid[v_dest[i]] || exp_mem[v_dest[i]] !== v_prod[i]) begin
                $display("Golden vector %0d expects address %0d to hold an earlier result",
                         i, v_dest[i]);
                vec_errs++;
            end
        end else begin
            exp_mem[v_dest[i]]   = v_prod[i];
            exp_valid[v_dest[i]] = 1'b1;
        end
        check_word(v_dest[i], v_prod[i]);   // Before a later vector reuses the address
    endtask

    // Edges from start edge to busy low, with an optional second start on the same lane
    task automatic track_run(input int lane, input int comp, output int edges);
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            if (comp >= 0 && edges == 4) begin
                apply_inputs(comp, 1'b1);   // Lane is mid-run here
            end
            if (comp >= 0 && v_mode[comp] == 2 && edges == 5) begin
                drop_start(lane);           // One-cycle pulse
            end
            @(negedge clk);
        end while (lane_busy(lane));
    endtask

    task automatic run_solo(input int i, output int next);
        int lane;
        int comp;
        int edges;
        lane = v_lane[i];
        comp = -1;
        if (i + 1 < num_vec && (v_mode[i + 1] == 2 || v_mode[i + 1] == 3)) begin
            comp = i + 1;
        end
        idle_gap();
        @(posedge clk);
        apply_inputs(i, 1'b1);
        @(posedge clk);   // Start edge
        drop_start(lane);
        track_run(lane, comp, edges);
        check_edges(lane, run_edges, edges);
        next = i + 1;
        if (comp >= 0) begin
            next = i + 2;
            if (v_mode[comp] == 3) begin
                @(posedge clk);   // Held start taken on the first idle edge
                drop_start(lane);
                track_run(lane, -1, edges);
                check_edges(lane, run_edges, edges);
            end
        end
        prio_lane = 1 - lane;   // Pointer moves past the lane just granted
        record_result(i);
        if (comp >= 0) begin
            record_result(comp);
        end
    endtask

    task automatic run_pair(input int i);
        int edges;
        int fall0;
        int fall1;
        idle_gap();
        @(posedge clk);
        apply_inputs(i, 1'b1);
        apply_inputs(i + 1, 1'b1);
        @(posedge clk);   // Common start edge
        drop_start(0);
        drop_start(1);
        edges = 0;
        fall0 = 0;
        fall1 = 0;
        while (fall0 == 0 || fall1 == 0) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (!busy0 && fall0 == 0) begin
                fall0 = edges;
            end
            if (!busy1 && fall1 == 0) begin
                fall1 = edges;
            end
        end
        // Favoured lane at solo latency, loser one write slot later
        if (prio_lane == 0) begin
            check_edges(0, run_edges, fall0);
            check_edges(1, run_edges + 1, fall1);
        end else begin
            check_edges(1, run_edges, fall1);
            check_edges(0, run_edges + 1, fall0);
        end
        // Two grants in a row bring the pointer back to the same lane
        record_result(i);
        record_result(i + 1);
    endtask

    task automatic read_back();
        logic [prod_width-1:0] prev;
        logic                  have_prev;
        have_prev = 1'b0;
        for (int a = 0; a < ram_depth; a++) begin
            if (exp_valid[a]) begin
                @(posedge clk);
                rd_addr <= addr_width'(a);
                @(negedge clk);
                if (have_prev && rd_data !== prev) begin   // Still the old word
                    $display("Fail at time %0t: rd_data before address %0d expected %h actual %h",
                             $time, a, prev, rd_data);
                    data_errs++;
                end
                @(negedge clk);
                if (rd_data !== exp_mem[a]) begin
                    $display("Fail at time %0t: rd_data at address %0d expected %h actual %h",
                             $time, a, exp_mem[a], rd_data);
                    data_errs++;
                end
                prev      = exp_mem[a];
                have_prev = 1'b1;
            end
        end
    endtask

    initial begin
        int i;
        int nxt;
        int seed;
        rst_n       = 1'b0;
        start0      = 1'b0;
        mplier0     = '0;
        mcand0      = '0;
        dest0       = '0;
        start1      = 1'b0;
        mplier1     = '0;
        mcand1      = '0;
        dest1       = '0;
        rd_addr     = '0;
        data_errs   = 0;
        timing_errs = 0;
        vec_errs    = 0;
        vec_loaded  = 1'b0;
        prio_lane   = 0;   // Lane 0 first after reset
        for (int a = 0; a < ram_depth; a++) begin
            exp_valid[a] = 1'b0;
        end
        seed = 32'he9b1_7dd4;
        seed = $urandom(seed);   // Gap generator seeded once
        read_vectors();
        vec_loaded = 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        i = 0;
        while (i < num_vec) begin
            if (v_mode[i] == 0) begin
                run_solo(i, nxt);
                i = nxt;
            end else if (v_mode[i] == 1 && i + 1 < num_vec) begin
                run_pair(i);
                i += 2;
            end else begin
                $display("Golden vector %0d has no run to attach to", i);
                vec_errs++;
                i++;
            end
        end
        read_back();
        $display("Errors: data %0d, timing %0d, vector file %0d",
                 data_errs, timing_errs, vec_errs);
        if (data_errs + timing_errs + vec_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog scaled to the vector count
    initial begin
        wait (vec_loaded);
        repeat (num_vec * 40 + 100) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", num_vec * 40 + 100);
        $display("Errors: data %0d, timing %0d, vector file %0d",
                 data_errs, timing_errs, vec_errs);
        $display("test failed");
        $finish;
    end

endmodule

/* hdl/mul_cluster.sv */
module mul_cluster (
    input  logic                             clk,
    input  logic                             rst_n,
    // Lane 0
    input  logic                             start0,
    input  logic [booth_pkg::op_width-1:0]   mplier0,
    input  logic [booth_pkg::op_width-1:0]   mcand0,
    input  logic [booth_pkg::addr_width-1:0] dest0,
    output logic                             busy0,
    // Lane 1
    input  logic                             start1,
    input  logic [booth_pkg::op_width-1:0]   mplier1,
    input  logic [booth_pkg::op_width-1:0]   mcand1,
    input  logic [booth_pkg::addr_width-1:0] dest1,
    output logic                             busy1,
    // Result read port
    input  logic [booth_pkg::addr_width-1:0] rd_addr,
    output logic [booth_pkg::prod_width-1:0] rd_data
);

    import booth_pkg::*;

    // Lane 0 internals
    logic                  load0, step0, clear0, count_done0, wr_req0;
    alu_op_e               alu_op0;
    logic [1:0]            q_pair0;
    logic [prod_width-1:0] product0;
    logic [addr_width-1:0] wr_addr0;

    // Lane 1 internals
    logic                  load1, step1, clear1, count_done1, wr_req1;
    alu_op_e               alu_op1;
    logic [1:0]            q_pair1;
    logic [prod_width-1:0] product1;
    logic [addr_width-1:0] wr_addr1;

    // Arbiter to RAM
    logic [num_lanes-1:0]  grant;
    logic                  ram_we;
    logic [addr_width-1:0] ram_waddr;
    logic [prod_width-1:0] ram_wdata;

    booth_control ctl0 (
        .clk(clk), .rst_n(rst_n), .start(start0), .dest(dest0),
        .q_pair(q_pair0), .count_done(count_done0), .grant(grant[0]),
        .load(load0), .step(step0), .clear(clear0), .alu_op(alu_op0),
        .busy(busy0), .wr_req(wr_req0), .wr_addr(wr_addr0)
    );

    booth_datapath dp0 (
        .clk(clk), .rst_n(rst_n), .multiplier(mplier0), .multiplicand(mcand0),
        .load(load0), .step(step0), .clear(clear0), .alu_op(alu_op0),
        .q_pair(q_pair0), .count_done(count_done0), .product(product0)
    );

    booth_control ctl1 (
        .clk(clk), .rst_n(rst_n), .start(start1), .dest(dest1),
        .q_pair(q_pair1), .count_done(count_done1), .grant(grant[1]),
        .load(load1), .step(step1), .clear(clear1), .alu_op(alu_op1),
        .busy(busy1), .wr_req(wr_req1), .wr_addr(wr_addr1)
    );

    booth_datapath dp1 (
        .clk(clk), .rst_n(rst_n), .multiplier(mplier1), .multiplicand(mcand1),
        .load(load1), .step(step1), .clear(clear1), .alu_op(alu_op1),
        .q_pair(q_pair1), .count_done(count_done1), .product(product1)
    );

    // Lane 1 in the upper slot of each vector
    result_arbiter arb0 (
        .clk(clk), .rst_n(rst_n),
        .req({wr_req1, wr_req0}),
        .waddr_in({wr_addr1, wr_addr0}),
        .wdata_in({product1, product0}),
        .grant(grant), .ram_we(ram_we), .ram_waddr(ram_waddr), .ram_wdata(ram_wdata)
    );

    result_ram ram0 (
        .clk(clk), .we(ram_we), .waddr(ram_waddr), .raddr(rd_addr),
        .wdata(ram_wdata), .rdata(rd_data)
    );

endmodule

/* hdl/result_ram.sv */
module result_ram (
    input  logic                             clk,
    input  logic                             we,
    input  logic [booth_pkg::addr_width-1:0] waddr,
    input  logic [booth_pkg::addr_width-1:0] raddr,
    input  logic [booth_pkg::prod_width-1:0] wdata,
    output logic [booth_pkg::prod_width-1:0] rdata   // Valid one cycle after raddr
);

    import booth_pkg::*;

    logic [prod_width-1:0] mem [ram_depth];

    // Single write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* hdl/result_arbiter.sv */
module result_arbiter (
    input  logic                                                     clk,
    input  logic                                                     rst_n,
    input  logic [booth_pkg::num_lanes-1:0]                          req,
    input  logic [booth_pkg::num_lanes-1:0][booth_pkg::addr_width-1:0] waddr_in,
    input  logic [booth_pkg::num_lanes-1:0][booth_pkg::prod_width-1:0] wdata_in,
    output logic [booth_pkg::num_lanes-1:0]                          grant,     // One-hot or zero
    output logic                                                     ram_we,
    output logic [booth_pkg::addr_width-1:0]                         ram_waddr,
    output logic [booth_pkg::prod_width-1:0]                         ram_wdata
);

    import booth_pkg::*;

    logic [lane_idx_width-1:0] ptr;   // Highest-priority lane this cycle
    logic [lane_idx_width-1:0] win;   // Granted lane

    // Search starting at the pointer, first requester wins
    always_comb begin
        int   idx;
        logic found;
        grant = '0;
        win   = '0;
        found = 1'b0;
        for (int i = 0; i < num_lanes; i++) begin
            idx = (int'(ptr) + i) % num_lanes;
            if (!found && req[idx]) begin
                found      = 1'b1;
                grant[idx] = 1'b1;
                win        = lane_idx_width'(idx);
            end
        end
    end

    // Rotate priority past the winner
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;   // Lane 0 first after reset
        end else if (|req) begin
            ptr <= (int'(win) == num_lanes - 1) ? '0 : win + 1'b1;
        end
    end

    // Winner's write to the RAM
    assign ram_we    = |grant;
    assign ram_waddr = waddr_in[win];
    assign ram_wdata = wdata_in[win];

    a_grant_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(grant) && ((grant & ~req) == '0)
    ) else $error("illegal grant vector");

endmodule

/* hdl/booth_control.sv */
module booth_control (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,        // One-cycle strobe
    input  logic [booth_pkg::addr_width-1:0] dest,
    input  logic [1:0]                       q_pair,       // {Q0, Q-1} from datapath
    input  logic                             count_done,
    input  logic                             grant,        // This lane's arbiter grant
    output logic                             load,
    output logic                             step,
    output logic                             clear,
    output booth_pkg::alu_op_e               alu_op,
    output logic                             busy,
    output logic                             wr_req,
    output logic [booth_pkg::addr_width-1:0] wr_addr
);

    import booth_pkg::*;

    lane_state_e           state;
    lane_state_e           state_nxt;
    logic [addr_width-1:0] dest_q;   // Destination for the result write

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_nxt = st_load;   // Accepted only here
                end
            end
            st_load:  state_nxt = st_run;
            st_run: begin
                if (count_done) begin
                    state_nxt = st_write;
                end
            end
            st_write: begin
                if (grant) begin
                    state_nxt = st_idle;   // Write lands on this edge
                end
            end
            default:  state_nxt = st_idle;
        endcase
    end

    // Latch destination on an accepted start
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            dest_q <= dest;
        end
    end

    // Booth recoding of the current bit pair
    always_comb begin
        case (q_pair)
            2'b10:   alu_op = alu_sub;
            2'b01:   alu_op = alu_add;
            default: alu_op = alu_pass;   // 00 or 11
        endcase
    end

    assign load    = (state == st_load);
    assign step    = (state == st_run) && !count_done;
    assign clear   = (state == st_idle);
    assign busy    = (state != st_idle);
    assign wr_req  = (state == st_write);
    assign wr_addr = dest_q;

    // Request and its address held until granted
    a_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_req && !grant |=> wr_req && $stable(wr_addr)
    ) else $error("wr_req dropped before grant");

    // A start on a busy lane neither restarts it nor retargets it
    a_start_ignored: assert property (
        @(posedge clk) disable iff (!rst_n)
        start && busy |=> state != st_load && $stable(wr_addr)
    ) else $error("start accepted while busy");

    // Load through all iterations to the write request
    a_run_length: assert property (
        @(posedge clk) disable iff (!rst_n)
        state == st_load |-> ##(iter_count + 2) state == st_write
    ) else $error("wrong iteration count before write request");

endmodule

/* hdl/booth_datapath.sv */
module booth_datapath (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [booth_pkg::op_width-1:0]  multiplier,     // Q operand, sampled on load
    input  logic [booth_pkg::op_width-1:0]  multiplicand,   // M operand, sampled on load
    input  logic                            load,
    input  logic                            step,
    input  logic                            clear,          // Held by controller while idle
    input  booth_pkg::alu_op_e              alu_op,
    output logic [1:0]                      q_pair,         // {Q0, Q-1}
    output logic                            count_done,
    output logic [booth_pkg::prod_width-1:0] product
);

    import booth_pkg::*;

    // Operand and working registers
    logic [op_width-1:0]   mcand_q;    // M
    logic [op_width-1:0]   acc_q;      // A
    logic [op_width-1:0]   mplier_q;   // Q
    logic                  q_m1;       // Q-1
    logic [cnt_width-1:0]  count;

    // One guard bit so A - M keeps its true sign when M is the most negative value
    logic [op_width:0]     mcand_ext;
    logic [op_width:0]     acc_ext;
    logic [op_width:0]     alu_out;

    // Next values after the arithmetic shift
    logic [op_width-1:0]   acc_nxt;
    logic [op_width-1:0]   mplier_nxt;
    logic                  q_m1_nxt;
    logic                  last_step;

    assign mcand_ext = {mcand_q[op_width-1], mcand_q};   // Sign extend
    assign acc_ext   = {acc_q[op_width-1], acc_q};

    // Add, subtract or pass
    always_comb begin
        case (alu_op)
            alu_add: alu_out = acc_ext + mcand_ext;
            alu_sub: alu_out = acc_ext - mcand_ext;
            default: alu_out = acc_ext;   // alu_pass
        endcase
    end

    // Shift {A, Q, Q-1} right by one, sign taken from the guard bit
    assign acc_nxt    = alu_out[op_width:1];
    assign mplier_nxt = {alu_out[0], mplier_q[op_width-1:1]};
    assign q_m1_nxt   = mplier_q[0];

    assign last_step  = step && (count == cnt_width'(iter_count - 1));

    // Counter and Q-1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            q_m1  <= 1'b0;
        end else if (clear || load) begin
            count <= '0;   // Fresh start for every operation
            q_m1  <= 1'b0;
        end else if (step) begin
            count <= count + 1'b1;
            q_m1  <= q_m1_nxt;
        end
    end

    // Operand registers and accumulator
    always_ff @(posedge clk) begin
        if (load) begin
            mcand_q  <= multiplicand;
            mplier_q <= multiplier;
            acc_q    <= '0;
        end else if (step) begin
            acc_q    <= acc_nxt;
            mplier_q <= mplier_nxt;
        end
    end

    // Product register, loaded once per operation and then held
    always_ff @(posedge clk) begin
        if (last_step) begin
            product <= {acc_nxt, mplier_nxt};
        end
    end

    assign q_pair     = {mplier_q[0], q_m1};
    assign count_done = (count == cnt_width'(iter_count));

    // Controller must stop stepping once all iterations are done
    a_no_step_after_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(step && count_done)
    ) else $error("step asserted with count_done high");

endmodule

/* hdl/booth_pkg.sv */
package booth_pkg;

    // Operand and product widths
    localparam int op_width   = 16;
    localparam int prod_width = 2 * op_width;   // Full signed product

    // One Booth iteration per multiplier bit
    localparam int iter_count = op_width;
    localparam int cnt_width  = $clog2(iter_count) + 1;   // Must reach iter_count itself

    // Cluster sizing
    localparam int num_lanes      = 2;
    localparam int lane_idx_width = (num_lanes > 1) ? $clog2(num_lanes) : 1;

    // Result memory
    localparam int addr_width = 4;
    localparam int ram_depth  = 1 << addr_width;   // 16 words

    // ALU operation applied to the accumulator on each step
    typedef enum logic [1:0] {
        alu_pass = 2'b00,   // Booth pair 00 or 11
        alu_add  = 2'b01,   // Booth pair 01
        alu_sub  = 2'b10    // Booth pair 10
    } alu_op_e;

    // Per-lane controller states
    typedef enum logic [1:0] {
        st_idle  = 2'b00,
        st_load  = 2'b01,
        st_run   = 2'b10,
        st_write = 2'b11
    } lane_state_e;

endpackage
